// File: pq_config_pkg.sv
package pq_config_pkg;

    // ------------------------------------------------------------------------
    // Queue geometry
    // ------------------------------------------------------------------------

    // Number of request slots
    localparam int NUM_ENTRIES = 4;

    // Slot index width, enough to address every slot
    localparam int INDEX_W = 2;

    // ------------------------------------------------------------------------
    // Entry field widths
    // ------------------------------------------------------------------------

    localparam int ZONE_W = 8;

    // Larger value is more urgent
    localparam int PRI_W = 2;

    // Waiting counter
    localparam int WAIT_W = 8;

    // Counter stops here instead of wrapping back to zero
    localparam logic [WAIT_W-1:0] WAIT_MAX = {WAIT_W{1'b1}};

endpackage

// File: pq_types_pkg.sv
package pq_types_pkg;

    import pq_config_pkg::*;

    // Zone id carried by every request
    typedef logic [ZONE_W-1:0] zone_t;

    // Request priority, 3 is the most urgent
    typedef logic [PRI_W-1:0] pri_t;

    // Cycles an entry has spent in the queue
    typedef logic [WAIT_W-1:0] wait_t;

    // Slot number inside the queue
    typedef logic [INDEX_W-1:0] slot_idx_t;

endpackage

// File: request_slot.sv
`timescale 1ns/10ps

module request_slot
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  write_en,
    input  zone_t zone_in,
    input  pri_t  pri_in,
    input  wait_t threshold,
    input  logic  clear,
    output zone_t zone,
    output pri_t  pri,
    output wait_t wait_time,
    output logic  boost,
    output logic  valid
);

    logic age_hit;
    logic at_max;

    // Old enough to be boosted, checked on the registered count
    assign age_hit = (wait_time >= threshold);
    assign at_max  = (wait_time == WAIT_MAX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zone      <= '0;
            pri       <= '0;
            wait_time <= '0;
            boost     <= 1'b0;
            valid     <= 1'b0;
        end else if (clear) begin
            // Served or cancelled, the slot becomes free
            zone      <= '0;
            pri       <= '0;
            wait_time <= '0;
            boost     <= 1'b0;
            valid     <= 1'b0;
        end else if (write_en) begin
            zone      <= zone_in;
            pri       <= pri_in;
            wait_time <= '0;
            boost     <= 1'b0;
            valid     <= 1'b1;
        end else if (valid) begin
            // Saturate so an old request never looks new again
            if (!at_max) begin
                wait_time <= wait_time + wait_t'(1);
            end
            // Sticky until the slot is cleared
            if (age_hit) begin
                boost <= 1'b1;
            end
        end
    end

endmodule

// File: slot_array.sv
`timescale 1ns/10ps

module slot_array
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      insert,
    input  zone_t     new_zone,
    input  pri_t      new_priority,
    input  wait_t     threshold,
    input  logic      serve,
    input  logic      cancel,
    input  zone_t     cancel_zone,
    input  slot_idx_t head_idx,
    output zone_t     slot_zone  [NUM_ENTRIES],
    output pri_t      slot_pri   [NUM_ENTRIES],
    output wait_t     slot_wait  [NUM_ENTRIES],
    output logic      slot_boost [NUM_ENTRIES],
    output logic      slot_valid [NUM_ENTRIES],
    output logic      queue_full
);

    logic write_en   [NUM_ENTRIES];
    logic serve_hit  [NUM_ENTRIES];
    logic cancel_hit [NUM_ENTRIES];
    logic slot_clear [NUM_ENTRIES];

    // ------------------------------------------------------------------------
    // Insert allocation
    // ------------------------------------------------------------------------

    // Lowest-numbered free slot takes the new request, nothing when full
    always_comb begin
        logic free_seen;
        free_seen = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_en[i] = insert && !slot_valid[i] && !free_seen;
            if (!slot_valid[i]) begin
                free_seen = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Serve and cancel decoding, slot storage
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_slot
        // Serve hits the current head only, an empty queue ignores it
        assign serve_hit[i] = serve && slot_valid[i] && (head_idx == slot_idx_t'(i));

        // Cancel hits every valid slot of that zone
        assign cancel_hit[i] = cancel && slot_valid[i] && (slot_zone[i] == cancel_zone);

        assign slot_clear[i] = serve_hit[i] || cancel_hit[i];

        request_slot i_request_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .write_en  (write_en[i]),
            .zone_in   (new_zone),
            .pri_in    (new_priority),
            .threshold (threshold),
            .clear     (slot_clear[i]),
            .zone      (slot_zone[i]),
            .pri       (slot_pri[i]),
            .wait_time (slot_wait[i]),
            .boost     (slot_boost[i]),
            .valid     (slot_valid[i])
        );
    end

    // Full when no slot is free
    always_comb begin
        queue_full = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            queue_full = queue_full && slot_valid[i];
        end
    end

endmodule

// File: pair_arbiter.sv
`timescale 1ns/10ps

module pair_arbiter
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  zone_t a_zone,
    input  pri_t  a_pri,
    input  wait_t a_wait,
    input  logic  a_boost,
    input  logic  a_valid,
    input  zone_t b_zone,
    input  pri_t  b_pri,
    input  wait_t b_wait,
    input  logic  b_boost,
    input  logic  b_valid,
    output zone_t win_zone,
    output pri_t  win_pri,
    output wait_t win_wait,
    output logic  win_boost,
    output logic  win_valid,
    output logic  pick_a
);

    logic valid_tie;
    logic boost_tie;
    logic pri_tie;

    assign valid_tie = (a_valid == b_valid);
    assign boost_tie = (a_boost == b_boost);
    assign pri_tie   = (a_pri == b_pri);

    // Valid, then boost, then priority, then the older entry
    // Full tie keeps side a, the lower slot
    always_comb begin
        if (!valid_tie) begin
            pick_a = a_valid;
        end else if (!boost_tie) begin
            pick_a = a_boost;
        end else if (!pri_tie) begin
            pick_a = (a_pri > b_pri);
        end else begin
            pick_a = (a_wait >= b_wait);
        end
    end

    // Winner fields
    assign win_zone  = pick_a ? a_zone  : b_zone;
    assign win_pri   = pick_a ? a_pri   : b_pri;
    assign win_wait  = pick_a ? a_wait  : b_wait;
    assign win_boost = pick_a ? a_boost : b_boost;
    assign win_valid = pick_a ? a_valid : b_valid;

endmodule

// File: arbitration_tree.sv
`timescale 1ns/10ps

module arbitration_tree
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  zone_t     slot_zone  [NUM_ENTRIES],
    input  pri_t      slot_pri   [NUM_ENTRIES],
    input  wait_t     slot_wait  [NUM_ENTRIES],
    input  logic      slot_boost [NUM_ENTRIES],
    input  logic      slot_valid [NUM_ENTRIES],
    output zone_t     head_zone,
    output pri_t      head_pri,
    output logic      head_boost,
    output logic      head_valid,
    output slot_idx_t head_idx
);

    // First-level winners
    zone_t lo_zone, hi_zone;
    pri_t  lo_pri, hi_pri;
    wait_t lo_wait, hi_wait;
    logic  lo_boost, hi_boost;
    logic  lo_valid, hi_valid;
    logic  pick_lo, pick_hi, pick_final;

    // ------------------------------------------------------------------------
    // Slots 0 and 1, slots 2 and 3
    // ------------------------------------------------------------------------

    pair_arbiter i_pair_lo (
        .a_zone (slot_zone[0]), .a_pri (slot_pri[0]), .a_wait (slot_wait[0]),
        .a_boost (slot_boost[0]), .a_valid (slot_valid[0]),
        .b_zone (slot_zone[1]), .b_pri (slot_pri[1]), .b_wait (slot_wait[1]),
        .b_boost (slot_boost[1]), .b_valid (slot_valid[1]),
        .win_zone (lo_zone), .win_pri (lo_pri), .win_wait (lo_wait),
        .win_boost (lo_boost), .win_valid (lo_valid), .pick_a (pick_lo)
    );

    pair_arbiter i_pair_hi (
        .a_zone (slot_zone[2]), .a_pri (slot_pri[2]), .a_wait (slot_wait[2]),
        .a_boost (slot_boost[2]), .a_valid (slot_valid[2]),
        .b_zone (slot_zone[3]), .b_pri (slot_pri[3]), .b_wait (slot_wait[3]),
        .b_boost (slot_boost[3]), .b_valid (slot_valid[3]),
        .win_zone (hi_zone), .win_pri (hi_pri), .win_wait (hi_wait),
        .win_boost (hi_boost), .win_valid (hi_valid), .pick_a (pick_hi)
    );

    // Final round, head waiting time is not needed outside
    pair_arbiter i_pair_final (
        .a_zone (lo_zone), .a_pri (lo_pri), .a_wait (lo_wait),
        .a_boost (lo_boost), .a_valid (lo_valid),
        .b_zone (hi_zone), .b_pri (hi_pri), .b_wait (hi_wait),
        .b_boost (hi_boost), .b_valid (hi_valid),
        .win_zone (head_zone), .win_pri (head_pri), .win_wait (),
        .win_boost (head_boost), .win_valid (head_valid), .pick_a (pick_final)
    );

    // MSB says which half won, LSB which slot inside it
    assign head_idx = pick_final ? {1'b0, ~pick_lo} : {1'b1, ~pick_hi};

endmodule

// File: priority_queue.sv
`timescale 1ns/10ps

module priority_queue
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  insert,
    input  zone_t new_zone,
    input  pri_t  new_priority,
    input  wait_t threshold,
    input  logic  serve,
    input  logic  cancel,
    input  zone_t cancel_zone,
    output zone_t head_zone,
    output pri_t  head_pri,
    output logic  head_boost,
    output logic  head_valid,
    output logic  queue_full
);

    // Per-slot state from storage to arbitration
    zone_t     slot_zone  [NUM_ENTRIES];
    pri_t      slot_pri   [NUM_ENTRIES];
    wait_t     slot_wait  [NUM_ENTRIES];
    logic      slot_boost [NUM_ENTRIES];
    logic      slot_valid [NUM_ENTRIES];

    // Head slot back to storage for serve
    slot_idx_t head_idx;

    slot_array i_slot_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .insert       (insert),
        .new_zone     (new_zone),
        .new_priority (new_priority),
        .threshold    (threshold),
        .serve        (serve),
        .cancel       (cancel),
        .cancel_zone  (cancel_zone),
        .head_idx     (head_idx),
        .slot_zone    (slot_zone),
        .slot_pri     (slot_pri),
        .slot_wait    (slot_wait),
        .slot_boost   (slot_boost),
        .slot_valid   (slot_valid),
        .queue_full   (queue_full)
    );

    arbitration_tree i_arbitration_tree (
        .slot_zone  (slot_zone),
        .slot_pri   (slot_pri),
        .slot_wait  (slot_wait),
        .slot_boost (slot_boost),
        .slot_valid (slot_valid),
        .head_zone  (head_zone),
        .head_pri   (head_pri),
        .head_boost (head_boost),
        .head_valid (head_valid),
        .head_idx   (head_idx)
    );

endmodule

// File: pq_assertions.sv
`timescale 1ns/10ps

module pq_assertions
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  slot_valid [NUM_ENTRIES],
    input zone_t head_zone,
    input pri_t  head_pri,
    input logic  head_boost,
    input logic  head_valid,
    input logic  queue_full
);

    int   failures = 0;
    logic any_valid;

    always_comb begin
        any_valid = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            any_valid = any_valid || slot_valid[i];
        end
    end

    // Head present exactly when some slot holds a request
    head_matches_slots: assert property (
        @(posedge clk) disable iff (!rst_n) head_valid == any_valid
    ) else begin
        $error("head_valid disagrees with the slot valid bits");
        failures++;
    end

    full_has_head: assert property (
        @(posedge clk) disable iff (!rst_n) queue_full |-> head_valid
    ) else begin
        $error("queue_full high while head_valid is low");
        failures++;
    end

    outputs_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> (!head_valid && !head_boost && !queue_full
                                   && head_zone == '0 && head_pri == '0)
    ) else begin
        $error("outputs not cleared during reset");
        failures++;
    end

    boost_has_head: assert property (
        @(posedge clk) disable iff (!rst_n) head_boost |-> head_valid
    ) else begin
        $error("head_boost high without a valid head");
        failures++;
    end

endmodule

bind priority_queue pq_assertions i_pq_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .slot_valid (slot_valid),
    .head_zone  (head_zone),
    .head_pri   (head_pri),
    .head_boost (head_boost),
    .head_valid (head_valid),
    .queue_full (queue_full)
);

// File: pq_checker.sv
`timescale 1ns/10ps

module pq_checker
    import pq_config_pkg::*, pq_types_pkg::*;
(
    input  logic            clk,
    input  logic            row_active,
    input  logic            check_en,
    input  logic            last_row,
    input  logic            report,
    input  int              test_num,
    input  logic [8*12-1:0] test_name,
    input  logic            exp_valid,
    input  zone_t           exp_zone,
    input  pri_t            exp_pri,
    input  logic            exp_boost,
    input  logic            exp_full,
    input  logic            head_valid,
    input  zone_t           head_zone,
    input  pri_t            head_pri,
    input  logic            head_boost,
    input  logic            queue_full,
    output int              tests_bad
);

    // 1 ns before the next rising edge of the 20 ns clock
    localparam int SAMPLE_DELAY = 19;

    int test_errors  = 0;
    int value_errors = 0;
    int tests_ok     = 0;
    int bad_count    = 0;

    assign tests_bad = bad_count;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_ok++;
            $display("test %0d %0s: ok", test_num, test_name);
        end else begin
            bad_count++;
            $display("test %0d %0s: %0d mismatches", test_num, test_name, test_errors);
        end
        value_errors += test_errors;
        test_errors = 0;
    endtask

    // Outputs are settled late in the cycle
    always begin
        @(posedge clk);
        #(SAMPLE_DELAY);
        if (row_active) begin
            if (check_en) begin
                compare_field("head_valid", 32'(exp_valid), 32'(head_valid));
                compare_field("head_zone", 32'(exp_zone), 32'(head_zone));
                compare_field("head_pri", 32'(exp_pri), 32'(head_pri));
                compare_field("head_boost", 32'(exp_boost), 32'(head_boost));
                compare_field("queue_full", 32'(exp_full), 32'(queue_full));
            end
            if (last_row) begin
                close_test();
            end
        end
    end

    always @(posedge report) begin
        $display("summary: %0d tests ok, %0d tests with mismatches, %0d value errors",
                 tests_ok, bad_count, value_errors);
    end

endmodule

// File: tb_priority_queue.sv
`timescale 1ns/10ps

module tb_priority_queue
    import pq_config_pkg::*, pq_types_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int MARGIN       = 100;

    // One table row, expected values hold after the row's edge
    typedef struct packed {
        int              num;
        logic [8*12-1:0] name;
        logic            ins;
        zone_t           zone;
        pri_t            pri;
        logic            srv;
        logic            can;
        zone_t           czone;
        wait_t           thr;
        logic            e_valid;
        zone_t           e_zone;
        pri_t            e_pri;
        logic            e_boost;
        logic            e_full;
        logic            chk;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic            insert;
    logic            serve;
    logic            cancel;
    zone_t           new_zone;
    zone_t           cancel_zone;
    pri_t            new_priority;
    wait_t           threshold;
    zone_t           head_zone;
    pri_t            head_pri;
    logic            head_boost;
    logic            head_valid;
    logic            queue_full;

    // Expected values for the checker
    logic            row_active;
    logic            check_en;
    logic            last_row;
    logic            report;
    int              test_num;
    logic [8*12-1:0] test_name;
    logic            exp_valid;
    zone_t           exp_zone;
    pri_t            exp_pri;
    logic            exp_boost;
    logic            exp_full;
    int              tests_bad;

    row_t            rows[$];
    int              cur_num;
    logic [8*12-1:0] cur_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    priority_queue i_priority_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .insert       (insert),
        .new_zone     (new_zone),
        .new_priority (new_priority),
        .threshold    (threshold),
        .serve        (serve),
        .cancel       (cancel),
        .cancel_zone  (cancel_zone),
        .head_zone    (head_zone),
        .head_pri     (head_pri),
        .head_boost   (head_boost),
        .head_valid   (head_valid),
        .queue_full   (queue_full)
    );

    pq_checker i_pq_checker (
        .clk        (clk),
        .row_active (row_active),
        .check_en   (check_en),
        .last_row   (last_row),
        .report     (report),
        .test_num   (test_num),
        .test_name  (test_name),
        .exp_valid  (exp_valid),
        .exp_zone   (exp_zone),
        .exp_pri    (exp_pri),
        .exp_boost  (exp_boost),
        .exp_full   (exp_full),
        .head_valid (head_valid),
        .head_zone  (head_zone),
        .head_pri   (head_pri),
        .head_boost (head_boost),
        .queue_full (queue_full),
        .tests_bad  (tests_bad)
    );

    task automatic begin_test(input int num, input logic [8*12-1:0] name);
        cur_num  = num;
        cur_name = name;
    endtask

    task automatic add_row(input int ins, input zone_t zone, input pri_t pri, input int srv,
                           input int can, input zone_t czone, input wait_t thr,
                           input int e_valid, input zone_t e_zone, input pri_t e_pri,
                           input int e_boost, input int e_full, input int chk);
        row_t r;
        r.num     = cur_num;
        r.name    = cur_name;
        r.ins     = (ins != 0);
        r.zone    = zone;
        r.pri     = pri;
        r.srv     = (srv != 0);
        r.can     = (can != 0);
        r.czone   = czone;
        r.thr     = thr;
        r.e_valid = (e_valid != 0);
        r.e_zone  = e_zone;
        r.e_pri   = e_pri;
        r.e_boost = (e_boost != 0);
        r.e_full  = (e_full != 0);
        r.chk     = (chk != 0);
        rows.push_back(r);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table, each test continues from the queue left by the one before
    // ------------------------------------------------------------------------

    task automatic build_table();
        // ins zone pri srv can czone thr | valid zone pri boost full chk
        begin_test(1, "priority");
        add_row(1, 8'h11, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'h11, 2'd1, 0, 0, 1);
        add_row(1, 8'h22, 2'd3, 0, 0, 8'h00, 8'd200, 1, 8'h22, 2'd3, 0, 0, 1);
        add_row(1, 8'h33, 2'd2, 0, 0, 8'h00, 8'd200, 1, 8'h22, 2'd3, 0, 0, 1);
        begin_test(3, "serve");
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 1, 8'h33, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 1, 8'h11, 2'd1, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 0, 8'h00, 2'd0, 0, 0, 1);
        // Serve on the empty queue keeps the insert beside it
        add_row(1, 8'h66, 2'd3, 1, 0, 8'h00, 8'd200, 1, 8'h66, 2'd3, 0, 0, 1);
        // Serve with insert frees slot 0, the later insert then lands below the older one
        begin_test(2, "age");
        add_row(1, 8'h44, 2'd2, 1, 0, 8'h00, 8'd200, 1, 8'h44, 2'd2, 0, 0, 1);
        add_row(1, 8'h55, 2'd2, 0, 0, 8'h00, 8'd200, 1, 8'h44, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 0, 8'h00, 8'd200, 1, 8'h44, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'h44, 8'd200, 1, 8'h55, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'h55, 8'd200, 0, 8'h00, 2'd0, 0, 0, 1);
        begin_test(4, "cancel");
        add_row(1, 8'h77, 2'd3, 0, 0, 8'h00, 8'd200, 1, 8'h77, 2'd3, 0, 0, 1);
        add_row(1, 8'h88, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'h77, 2'd3, 0, 0, 1);
        add_row(1, 8'h99, 2'd2, 0, 0, 8'h00, 8'd200, 1, 8'h77, 2'd3, 0, 0, 1);
        add_row(1, 8'h77, 2'd2, 0, 0, 8'h00, 8'd200, 1, 8'h77, 2'd3, 0, 1, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'hee, 8'd200, 1, 8'h77, 2'd3, 0, 1, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'h77, 8'd200, 1, 8'h99, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'h88, 8'd200, 1, 8'h99, 2'd2, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 1, 8'h99, 8'd200, 0, 8'h00, 2'd0, 0, 0, 1);
        begin_test(5, "full");
        add_row(1, 8'ha1, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'ha1, 2'd1, 0, 0, 1);
        add_row(1, 8'ha2, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'ha1, 2'd1, 0, 0, 1);
        add_row(1, 8'ha3, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'ha1, 2'd1, 0, 0, 1);
        add_row(1, 8'ha4, 2'd1, 0, 0, 8'h00, 8'd200, 1, 8'ha1, 2'd1, 0, 1, 1);
        add_row(1, 8'ha5, 2'd3, 0, 0, 8'h00, 8'd200, 1, 8'ha1, 2'd1, 0, 1, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 1, 8'ha2, 2'd1, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 1, 8'ha3, 2'd1, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 1, 8'ha4, 2'd1, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd200, 0, 8'h00, 2'd0, 0, 0, 1);
        // Threshold 3, old entry boosts four edges after its insert
        begin_test(6, "boost");
        add_row(1, 8'hb0, 2'd0, 0, 0, 8'h00, 8'd3, 1, 8'hb0, 2'd0, 0, 0, 1);
        add_row(1, 8'hb3, 2'd3, 0, 0, 8'h00, 8'd3, 1, 8'hb3, 2'd3, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 0, 8'h00, 8'd3, 1, 8'hb3, 2'd3, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 0, 8'h00, 8'd3, 1, 8'hb3, 2'd3, 0, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 0, 8'h00, 8'd3, 1, 8'hb0, 2'd0, 1, 0, 1);
        add_row(0, 8'h00, 2'd0, 0, 0, 8'h00, 8'd3, 1, 8'hb3, 2'd3, 1, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd3, 1, 8'hb0, 2'd0, 1, 0, 1);
        add_row(0, 8'h00, 2'd0, 1, 0, 8'h00, 8'd3, 0, 8'h00, 2'd0, 0, 0, 1);
    endtask

    task automatic drive_row(input row_t r);
        insert       = r.ins;
        new_zone     = r.zone;
        new_priority = r.pri;
        serve        = r.srv;
        cancel       = r.can;
        cancel_zone  = r.czone;
        threshold    = r.thr;
    endtask

    task automatic drive_idle();
        insert = 1'b0;
        serve  = 1'b0;
        cancel = 1'b0;
    endtask

    // Row k acted at the last edge, so its expected values apply now
    task automatic hand_expected(input int k);
        row_active = 1'b1;
        check_en   = rows[k].chk;
        last_row   = (k == rows.size() - 1) || (rows[k + 1].num != rows[k].num);
        test_num   = rows[k].num;
        test_name  = rows[k].name;
        exp_valid  = rows[k].e_valid;
        exp_zone   = rows[k].e_zone;
        exp_pri    = rows[k].e_pri;
        exp_boost  = rows[k].e_boost;
        exp_full   = rows[k].e_full;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        insert       = 1'b0;
        serve        = 1'b0;
        cancel       = 1'b0;
        new_zone     = '0;
        new_priority = '0;
        cancel_zone  = '0;
        threshold    = 8'd200;
        row_active   = 1'b0;
        check_en     = 1'b0;
        last_row     = 1'b0;
        report       = 1'b0;
        test_num     = 0;
        test_name    = '0;
        exp_valid    = 1'b0;
        exp_zone     = '0;
        exp_pri      = '0;
        exp_boost    = 1'b0;
        exp_full     = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            #1;
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                drive_idle();
            end
            if (i > 0) begin
                hand_expected(i - 1);
            end
        end
        @(posedge clk);
        #1;
        row_active = 1'b0;
        report     = 1'b1;
        #1;
        if (tests_bad == 0 && i_priority_queue.i_pq_assertions.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((rows.size() + RESET_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

// File: filelist.f
pq_config_pkg.sv
pq_types_pkg.sv
request_slot.sv
slot_array.sv
pair_arbiter.sv
arbitration_tree.sv
priority_queue.sv
pq_assertions.sv
pq_checker.sv
tb_priority_queue.sv

// File: Makefile
# Verilator build and run of the priority queue testbench

VERILATOR ?= verilator
TOP       ?= tb_priority_queue
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
LINTFLAGS ?= --lint-only -Wall --timing --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit status of the binary
run: $(BIN)
	./$(BIN) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message missing in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
